// ==== Makefile ====
VERILATOR  ?= verilator
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert -j 0
TOP        ?= tb_decode_top
FILELIST   ?= all.f
OBJ_DIR    ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

# the simulator exits non-zero on $fatal, which fails this target.
sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== all.f ====
+incdir+test
hw/mips_decode_pkg.sv
hw/id_stage1.sv
hw/id_stage_reg.sv
hw/id_stage2.sv
hw/decode_top.sv
test/tb_decode_top.sv

// ==== hw/decode_top.sv ====
`timescale 1ns/1ps

module decode_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [31:0]           inst,
    input  logic                  inst_valid,
    input  logic                  stall,
    input  logic                  flush,
    output mips_decode_pkg::dec_t dec
);

    mips_decode_pkg::id1_t id1_d;
    mips_decode_pkg::id1_t id1_q;

    // field split and one-hot match.
    id_stage1 i_id_stage1 (
        .inst       (inst),
        .inst_valid (inst_valid),
        .id1        (id1_d)
    );

    id_stage_reg i_id_stage_reg (
        .clk   (clk),
        .reset (reset),
        .stall (stall),
        .flush (flush),
        .d     (id1_d),
        .q     (id1_q)
    );

    // ALU, immediate and memory decode.
    id_stage2 i_id_stage2 (
        .id1 (id1_q),
        .dec (dec)
    );

endmodule

// ==== hw/id_stage1.sv ====
`timescale 1ns/1ps

module id_stage1 (
    input  mips_decode_pkg::inst_u inst,
    input  logic                   inst_valid,
    output mips_decode_pkg::id1_t  id1
);

    logic [28:0] op;
    logic [28:0] fn;
    logic        sp;
    logic        wr_rd;
    logic        wr_rt;
    logic        wr_ra;
    logic        no_wr;
    logic [4:0]  dst;

    // one match bit per known code, in enum order.
    always_comb begin
        for (int k = 0; k < 29; k++) begin
            op[k] = (inst.r.op == mips_decode_pkg::OP_CODE_TAB[k]);
            fn[k] = (inst.r.funct == mips_decode_pkg::FN_CODE_TAB[k]);
        end
    end

    assign sp = op[mips_decode_pkg::OP_SPECIAL];

    // ALU, shift, JALR and MFHI/MFLO functs occupy ADD..MFLO.
    assign wr_rd = sp & (|fn[mips_decode_pkg::FN_MFLO:mips_decode_pkg::FN_ADD]);

    // immediate ALU ops and loads occupy ADDI..LWR.
    assign wr_rt = (|op[mips_decode_pkg::OP_LWR:mips_decode_pkg::OP_ADDI]) |
                   (op[mips_decode_pkg::OP_COP0] & (inst.r.rs == mips_decode_pkg::MFC0_RS));

    // linking jumps and branches write the return address register.
    assign wr_ra = op[mips_decode_pkg::OP_JAL] |
                   (op[mips_decode_pkg::OP_REGIMM] &
                    ((inst.r.rt == mips_decode_pkg::BGEZAL_RT) |
                     (inst.r.rt == mips_decode_pkg::BLTZAL_RT)));

    // hi/lo, JR, trap and return functs occupy DIV..ERET.
    assign no_wr = (sp & (|fn[mips_decode_pkg::FN_ERET:mips_decode_pkg::FN_DIV])) |
                   (|op[mips_decode_pkg::OP_J:mips_decode_pkg::OP_BEQ]) |
                   (|op[mips_decode_pkg::OP_SWR:mips_decode_pkg::OP_SB]) |
                   (op[mips_decode_pkg::OP_REGIMM] &
                    ((inst.r.rt == mips_decode_pkg::BGEZ_RT) |
                     (inst.r.rt == mips_decode_pkg::BLTZ_RT))) |
                   (op[mips_decode_pkg::OP_COP0] & (inst.r.rs == mips_decode_pkg::MTC0_RS));

    always_comb begin
        if (wr_rd) begin
            dst = inst.r.rd;
        end else if (wr_rt) begin
            dst = inst.r.rt;
        end else if (wr_ra) begin
            dst = 5'd31;
        end else begin
            dst = 5'd0;
        end
    end

    always_comb begin
        id1.valid      = inst_valid;
        id1.inst       = inst;
        id1.op_codes   = op;
        id1.func_codes = fn;
        id1.w_reg_dst  = dst;
        // writes to r0 are dropped.
        id1.w_reg_ena  = ~no_wr & (dst != 5'd0);
        id1.is_branch  = (|op[mips_decode_pkg::OP_BLEZ:mips_decode_pkg::OP_JAL]) |
                         op[mips_decode_pkg::OP_REGIMM];
        id1.is_j_imme  = op[mips_decode_pkg::OP_J] | op[mips_decode_pkg::OP_JAL];
        id1.is_jr      = sp & (fn[mips_decode_pkg::FN_JR] | fn[mips_decode_pkg::FN_JALR]);
        id1.is_ls      = (|op[mips_decode_pkg::OP_LWR:mips_decode_pkg::OP_LB]) |
                         (|op[mips_decode_pkg::OP_SWR:mips_decode_pkg::OP_SB]);
        // MFHI..MULTU plus MTHI/MTLO.
        id1.is_hilo    = sp & ((|fn[mips_decode_pkg::FN_MULTU:mips_decode_pkg::FN_MFHI]) |
                               (|fn[mips_decode_pkg::FN_MTLO:mips_decode_pkg::FN_MTHI]));
    end

endmodule

// ==== hw/id_stage2.sv ====
`timescale 1ns/1ps

module id_stage2 (
    input  mips_decode_pkg::id1_t id1,
    output mips_decode_pkg::dec_t dec
);

    logic [28:0] op;
    logic [28:0] fn;
    logic        sp;
    logic [15:0] imm16;
    logic        zero_ext;
    logic        reserved;

    assign op       = id1.op_codes;
    assign fn       = id1.func_codes;
    assign sp       = op[mips_decode_pkg::OP_SPECIAL];
    assign imm16    = id1.inst.i.imm16;
    assign zero_ext = op[mips_decode_pkg::OP_ANDI] | op[mips_decode_pkg::OP_ORI] |
                      op[mips_decode_pkg::OP_XORI];
    // unknown opcode, or SPECIAL with no known funct.
    assign reserved = ~|op | (sp & ~|fn);

    always_comb begin
        dec.valid      = id1.valid;
        dec.rs         = id1.inst.r.rs;
        dec.rt         = id1.inst.r.rt;
        dec.sa         = id1.inst.r.sa;
        dec.w_reg_dst  = id1.w_reg_dst;
        dec.w_reg_ena  = id1.w_reg_ena & ~reserved;
        dec.j_target26 = id1.inst.j.target26;
        dec.is_branch  = id1.is_branch;
        dec.is_j_imme  = id1.is_j_imme;
        dec.is_jr      = id1.is_jr;
        dec.is_hilo    = id1.is_hilo;
        dec.reserved   = reserved;
        // immediate ALU ops occupy ADDI..XORI.
        dec.imm_src    = (|op[mips_decode_pkg::OP_XORI:mips_decode_pkg::OP_ADDI]) |
                         id1.is_ls;

        if (op[mips_decode_pkg::OP_LUI]) begin
            dec.imm32 = {imm16, 16'h0000};
        end else if (zero_ext) begin
            dec.imm32 = {16'h0000, imm16};
        end else begin
            dec.imm32 = {{16{imm16[15]}}, imm16};
        end

        dec.alu_op = mips_decode_pkg::ALU_PASS;
        if (sp) begin
            case (1'b1)
                fn[mips_decode_pkg::FN_ADD]:  dec.alu_op = mips_decode_pkg::ALU_ADD;
                fn[mips_decode_pkg::FN_ADDU]: dec.alu_op = mips_decode_pkg::ALU_ADDU;
                fn[mips_decode_pkg::FN_SUB]:  dec.alu_op = mips_decode_pkg::ALU_SUB;
                fn[mips_decode_pkg::FN_SUBU]: dec.alu_op = mips_decode_pkg::ALU_SUBU;
                fn[mips_decode_pkg::FN_SLT]:  dec.alu_op = mips_decode_pkg::ALU_SLT;
                fn[mips_decode_pkg::FN_SLTU]: dec.alu_op = mips_decode_pkg::ALU_SLTU;
                fn[mips_decode_pkg::FN_AND]:  dec.alu_op = mips_decode_pkg::ALU_AND;
                fn[mips_decode_pkg::FN_OR]:   dec.alu_op = mips_decode_pkg::ALU_OR;
                fn[mips_decode_pkg::FN_XOR]:  dec.alu_op = mips_decode_pkg::ALU_XOR;
                fn[mips_decode_pkg::FN_NOR]:  dec.alu_op = mips_decode_pkg::ALU_NOR;
                fn[mips_decode_pkg::FN_SLL], fn[mips_decode_pkg::FN_SLLV]:
                    dec.alu_op = mips_decode_pkg::ALU_SLL;
                fn[mips_decode_pkg::FN_SRL], fn[mips_decode_pkg::FN_SRLV]:
                    dec.alu_op = mips_decode_pkg::ALU_SRL;
                fn[mips_decode_pkg::FN_SRA], fn[mips_decode_pkg::FN_SRAV]:
                    dec.alu_op = mips_decode_pkg::ALU_SRA;
                default: dec.alu_op = mips_decode_pkg::ALU_PASS;
            endcase
        end else begin
            case (1'b1)
                // address generation for loads and stores.
                op[mips_decode_pkg::OP_ADDI], id1.is_ls:
                    dec.alu_op = mips_decode_pkg::ALU_ADD;
                op[mips_decode_pkg::OP_ADDIU]: dec.alu_op = mips_decode_pkg::ALU_ADDU;
                op[mips_decode_pkg::OP_SLTI]:  dec.alu_op = mips_decode_pkg::ALU_SLT;
                op[mips_decode_pkg::OP_SLTIU]: dec.alu_op = mips_decode_pkg::ALU_SLTU;
                op[mips_decode_pkg::OP_ANDI]:  dec.alu_op = mips_decode_pkg::ALU_AND;
                op[mips_decode_pkg::OP_ORI]:   dec.alu_op = mips_decode_pkg::ALU_OR;
                op[mips_decode_pkg::OP_XORI]:  dec.alu_op = mips_decode_pkg::ALU_XOR;
                op[mips_decode_pkg::OP_LUI]:   dec.alu_op = mips_decode_pkg::ALU_LUI;
                default: dec.alu_op = mips_decode_pkg::ALU_PASS;
            endcase
        end

        dec.mem_op = mips_decode_pkg::MEM_NONE;
        if (id1.is_ls) begin
            case (1'b1)
                op[mips_decode_pkg::OP_LB]:  dec.mem_op = mips_decode_pkg::MEM_LB;
                op[mips_decode_pkg::OP_LBU]: dec.mem_op = mips_decode_pkg::MEM_LBU;
                op[mips_decode_pkg::OP_LH]:  dec.mem_op = mips_decode_pkg::MEM_LH;
                op[mips_decode_pkg::OP_LHU]: dec.mem_op = mips_decode_pkg::MEM_LHU;
                op[mips_decode_pkg::OP_LW]:  dec.mem_op = mips_decode_pkg::MEM_LW;
                op[mips_decode_pkg::OP_LWL]: dec.mem_op = mips_decode_pkg::MEM_LWL;
                op[mips_decode_pkg::OP_LWR]: dec.mem_op = mips_decode_pkg::MEM_LWR;
                op[mips_decode_pkg::OP_SB]:  dec.mem_op = mips_decode_pkg::MEM_SB;
                op[mips_decode_pkg::OP_SH]:  dec.mem_op = mips_decode_pkg::MEM_SH;
                op[mips_decode_pkg::OP_SW]:  dec.mem_op = mips_decode_pkg::MEM_SW;
                op[mips_decode_pkg::OP_SWL]: dec.mem_op = mips_decode_pkg::MEM_SWL;
                op[mips_decode_pkg::OP_SWR]: dec.mem_op = mips_decode_pkg::MEM_SWR;
                default: dec.mem_op = mips_decode_pkg::MEM_NONE;
            endcase
        end
    end

endmodule

// ==== hw/id_stage_reg.sv ====
`timescale 1ns/1ps

module id_stage_reg (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  stall,
    input  logic                  flush,
    input  mips_decode_pkg::id1_t d,
    output mips_decode_pkg::id1_t q
);

    logic                  valid_q;
    mips_decode_pkg::id1_t data_q;

    // flush wins over stall.
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            valid_q <= 1'b0;
        end else if (!stall) begin
            valid_q <= d.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            data_q <= d;
        end
    end

    always_comb begin
        q       = data_q;
        q.valid = valid_q;
    end

endmodule

// ==== hw/mips_decode_pkg.sv ====
package mips_decode_pkg;

    // MIPS-I major opcodes.
    localparam logic [5:0]
        SPECIAL_OP = 6'h00, REGIMM_OP = 6'h01, J_OP     = 6'h02, JAL_OP   = 6'h03,
        BEQ_OP     = 6'h04, BNE_OP    = 6'h05, BLEZ_OP  = 6'h06, BGTZ_OP  = 6'h07,
        ADDI_OP    = 6'h08, ADDIU_OP  = 6'h09, SLTI_OP  = 6'h0a, SLTIU_OP = 6'h0b,
        ANDI_OP    = 6'h0c, ORI_OP    = 6'h0d, XORI_OP  = 6'h0e, LUI_OP   = 6'h0f,
        COP0_OP    = 6'h10, LB_OP     = 6'h20, LH_OP    = 6'h21, LWL_OP   = 6'h22,
        LW_OP      = 6'h23, LBU_OP    = 6'h24, LHU_OP   = 6'h25, LWR_OP   = 6'h26,
        SB_OP      = 6'h28, SH_OP     = 6'h29, SWL_OP   = 6'h2a, SW_OP    = 6'h2b,
        SWR_OP     = 6'h2e;

    // funct codes. ERET is the COP0 funct and shares its value with MULT.
    localparam logic [5:0]
        SLL_FN     = 6'h00, SRL_FN    = 6'h02, SRA_FN   = 6'h03, SLLV_FN  = 6'h04,
        SRLV_FN    = 6'h06, SRAV_FN   = 6'h07, JR_FN    = 6'h08, JALR_FN  = 6'h09,
        SYSCALL_FN = 6'h0c, BREAK_FN  = 6'h0d, MFHI_FN  = 6'h10, MTHI_FN  = 6'h11,
        MFLO_FN    = 6'h12, MTLO_FN   = 6'h13, MULT_FN  = 6'h18, MULTU_FN = 6'h19,
        DIV_FN     = 6'h1a, DIVU_FN   = 6'h1b, ADD_FN   = 6'h20, ADDU_FN  = 6'h21,
        SUB_FN     = 6'h22, SUBU_FN   = 6'h23, AND_FN   = 6'h24, OR_FN    = 6'h25,
        XOR_FN     = 6'h26, NOR_FN    = 6'h27, SLT_FN   = 6'h2a, SLTU_FN  = 6'h2b,
        ERET_FN    = 6'h18;

    // REGIMM rt selectors and COP0 rs selectors.
    localparam logic [4:0]
        BLTZ_RT   = 5'b00000, BGEZ_RT   = 5'b00001,
        BLTZAL_RT = 5'b10000, BGEZAL_RT = 5'b10001,
        MFC0_RS   = 5'b00000, MTC0_RS   = 5'b00100;

    // bit positions in the opcode vector. the decoders use the contiguous ranges.
    typedef enum logic [4:0] {
        OP_SPECIAL, OP_COP0, OP_REGIMM,
        OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_LUI, OP_ORI, OP_XORI,
        OP_LB, OP_LH, OP_LBU, OP_LHU, OP_LW, OP_LWL, OP_LWR,
        OP_JAL, OP_BEQ, OP_BNE, OP_BGTZ, OP_BLEZ, OP_J,
        OP_SB, OP_SH, OP_SW, OP_SWL, OP_SWR
    } op_idx_t;

    localparam logic [5:0] OP_CODE_TAB [29] = '{
        SPECIAL_OP, COP0_OP, REGIMM_OP,
        ADDI_OP, ADDIU_OP, SLTI_OP, SLTIU_OP, ANDI_OP, LUI_OP, ORI_OP, XORI_OP,
        LB_OP, LH_OP, LBU_OP, LHU_OP, LW_OP, LWL_OP, LWR_OP,
        JAL_OP, BEQ_OP, BNE_OP, BGTZ_OP, BLEZ_OP, J_OP,
        SB_OP, SH_OP, SW_OP, SWL_OP, SWR_OP
    };

    // bit positions in the funct vector.
    typedef enum logic [4:0] {
        FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_SLT, FN_SLTU, FN_AND, FN_NOR, FN_OR,
        FN_XOR, FN_SLLV, FN_SLL, FN_SRAV, FN_SRA, FN_SRLV, FN_SRL,
        FN_JALR, FN_MFHI, FN_MFLO, FN_DIV, FN_DIVU, FN_MULT, FN_MULTU,
        FN_JR, FN_MTHI, FN_MTLO, FN_BREAK, FN_SYSCALL, FN_ERET
    } fn_idx_t;

    localparam logic [5:0] FN_CODE_TAB [29] = '{
        ADD_FN, ADDU_FN, SUB_FN, SUBU_FN, SLT_FN, SLTU_FN, AND_FN, NOR_FN, OR_FN,
        XOR_FN, SLLV_FN, SLL_FN, SRAV_FN, SRA_FN, SRLV_FN, SRL_FN,
        JALR_FN, MFHI_FN, MFLO_FN, DIV_FN, DIVU_FN, MULT_FN, MULTU_FN,
        JR_FN, MTHI_FN, MTLO_FN, BREAK_FN, SYSCALL_FN, ERET_FN
    };

    typedef union packed {
        struct packed {
            logic [5:0] op;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] sa;
            logic [5:0] funct;
        } r;
        struct packed {
            logic [5:0]  op;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm16;
        } i;
        struct packed {
            logic [5:0]  op;
            logic [25:0] target26;
        } j;
    } inst_u;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU, ALU_SLT, ALU_SLTU,
        ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_LUI, ALU_PASS
    } alu_op_e;

    typedef enum logic [3:0] {
        MEM_NONE, MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW, MEM_LWL, MEM_LWR,
        MEM_SB, MEM_SH, MEM_SW, MEM_SWL, MEM_SWR
    } mem_op_e;

    typedef struct packed {
        logic        valid;
        inst_u       inst;
        logic [28:0] op_codes;
        logic [28:0] func_codes;
        logic        w_reg_ena;
        logic [4:0]  w_reg_dst;
        logic        is_branch;
        logic        is_j_imme;
        logic        is_jr;
        logic        is_ls;
        logic        is_hilo;
    } id1_t;

    typedef struct packed {
        logic        valid;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  sa;
        logic [4:0]  w_reg_dst;
        logic        w_reg_ena;
        alu_op_e     alu_op;
        logic [31:0] imm32;
        logic [25:0] j_target26;
        mem_op_e     mem_op;
        logic        is_branch;
        logic        is_j_imme;
        logic        is_jr;
        logic        is_hilo;
        logic        imm_src;
        logic        reserved;
    } dec_t;

endpackage

// ==== test/tb_decode_vectors.svh ====
`ifndef TB_DECODE_VECTORS_SVH
`define TB_DECODE_VECTORS_SVH

// each row holds the word, write enable, write register, alu_op, imm32, mem_op and the
// flags {is_branch, is_j_imme, is_jr, is_hilo, imm_src, reserved}.
// alu_op codes are add 0 addu 1 sub 2 subu 3 slt 4 sltu 5 and 6 or 7 xor 8 nor 9 sll 10
// srl 11 sra 12 lui 13 pass 14.
// mem_op codes are none 0 lb 1 lbu 2 lh 3 lhu 4 lw 5 lwl 6 lwr 7 sb 8 sh 9 sw 10 swl 11 swr 12.
typedef struct packed {
    logic [31:0] inst;
    logic        w_ena;
    logic [4:0]  w_dst;
    logic [3:0]  alu;
    logic [31:0] imm;
    logic [3:0]  mem;
    logic [5:0]  flags;
} vector_t;

localparam int NUM_VECTORS = 38;

localparam vector_t VECTORS [NUM_VECTORS] = '{
    '{32'h00221820, 1'b1, 5'd3,  4'd0,  32'h00001820, 4'd0,  6'b000000}, // add r3, r1, r2
    '{32'h00A62023, 1'b1, 5'd4,  4'd3,  32'h00002023, 4'd0,  6'b000000}, // subu r4, r5, r6
    '{32'h00220027, 1'b0, 5'd0,  4'd9,  32'h00000027, 4'd0,  6'b000000}, // nor r0, r1, r2
    '{32'h00083900, 1'b1, 5'd7,  4'd10, 32'h00003900, 4'd0,  6'b000000}, // sll r7, r8, 4
    '{32'h016A4807, 1'b1, 5'd9,  4'd12, 32'h00004807, 4'd0,  6'b000000}, // srav r9, r10, r11
    '{32'h2022FFFC, 1'b1, 5'd2,  4'd0,  32'hFFFFFFFC, 4'd0,  6'b000010}, // addi r2, r1, -4
    '{32'h2883FFFF, 1'b1, 5'd3,  4'd4,  32'hFFFFFFFF, 4'd0,  6'b000010}, // slti r3, r4, -1
    '{32'h34C58001, 1'b1, 5'd5,  4'd7,  32'h00008001, 4'd0,  6'b000010}, // ori r5, r6, 0x8001
    '{32'h3C081234, 1'b1, 5'd8,  4'd13, 32'h12340000, 4'd0,  6'b000010}, // lui r8, 0x1234
    '{32'h1022FFFE, 1'b0, 5'd0,  4'd14, 32'hFFFFFFFE, 4'd0,  6'b100000}, // beq r1, r2, -2
    '{32'h04610008, 1'b0, 5'd0,  4'd14, 32'h00000008, 4'd0,  6'b100000}, // bgez r3, 8
    '{32'h08100040, 1'b0, 5'd0,  4'd14, 32'h00000040, 4'd0,  6'b010000}, // j
    '{32'h0C100080, 1'b1, 5'd31, 4'd14, 32'h00000080, 4'd0,  6'b110000}, // jal
    '{32'h0491FFF0, 1'b1, 5'd31, 4'd14, 32'hFFFFFFF0, 4'd0,  6'b100000}, // bgezal r4, -16
    '{32'h03E00008, 1'b0, 5'd0,  4'd14, 32'h00000008, 4'd0,  6'b001000}, // jr r31
    '{32'h00A0F809, 1'b1, 5'd31, 4'd14, 32'hFFFFF809, 4'd0,  6'b001000}, // jalr r31, r5
    '{32'h8022FFFF, 1'b1, 5'd2,  4'd0,  32'hFFFFFFFF, 4'd1,  6'b000010}, // lb r2, -1(r1)
    '{32'h90230004, 1'b1, 5'd3,  4'd0,  32'h00000004, 4'd2,  6'b000010}, // lbu r3, 4(r1)
    '{32'h8424FFFE, 1'b1, 5'd4,  4'd0,  32'hFFFFFFFE, 4'd3,  6'b000010}, // lh r4, -2(r1)
    '{32'h94250006, 1'b1, 5'd5,  4'd0,  32'h00000006, 4'd4,  6'b000010}, // lhu r5, 6(r1)
    '{32'h8FA67FFC, 1'b1, 5'd6,  4'd0,  32'h00007FFC, 4'd5,  6'b000010}, // lw r6, 0x7ffc(r29)
    '{32'h88270003, 1'b1, 5'd7,  4'd0,  32'h00000003, 4'd6,  6'b000010}, // lwl r7, 3(r1)
    '{32'h98270000, 1'b1, 5'd7,  4'd0,  32'h00000000, 4'd7,  6'b000010}, // lwr r7, 0(r1)
    '{32'hA022FFF8, 1'b0, 5'd0,  4'd0,  32'hFFFFFFF8, 4'd8,  6'b000010}, // sb r2, -8(r1)
    '{32'hA4230002, 1'b0, 5'd0,  4'd0,  32'h00000002, 4'd9,  6'b000010}, // sh r3, 2(r1)
    '{32'hAFA4FFFC, 1'b0, 5'd0,  4'd0,  32'hFFFFFFFC, 4'd10, 6'b000010}, // sw r4, -4(r29)
    '{32'hA8250001, 1'b0, 5'd0,  4'd0,  32'h00000001, 4'd11, 6'b000010}, // swl r5, 1(r1)
    '{32'hB8260002, 1'b0, 5'd0,  4'd0,  32'h00000002, 4'd12, 6'b000010}, // swr r6, 2(r1)
    '{32'h00220018, 1'b0, 5'd0,  4'd14, 32'h00000018, 4'd0,  6'b000100}, // mult r1, r2
    '{32'h0064001A, 1'b0, 5'd0,  4'd14, 32'h0000001A, 4'd0,  6'b000100}, // div r3, r4
    '{32'h00A00011, 1'b0, 5'd0,  4'd14, 32'h00000011, 4'd0,  6'b000100}, // mthi r5
    '{32'h00C00013, 1'b0, 5'd0,  4'd14, 32'h00000013, 4'd0,  6'b000100}, // mtlo r6
    '{32'h00003810, 1'b1, 5'd7,  4'd14, 32'h00003810, 4'd0,  6'b000100}, // mfhi r7
    '{32'h00004012, 1'b1, 5'd8,  4'd14, 32'h00004012, 4'd0,  6'b000100}, // mflo r8
    '{32'h40046000, 1'b1, 5'd4,  4'd14, 32'h00006000, 4'd0,  6'b000000}, // mfc0 r4, $12
    '{32'h40846000, 1'b0, 5'd0,  4'd14, 32'h00006000, 4'd0,  6'b000000}, // mtc0 r4, $12
    '{32'hFC221234, 1'b0, 5'd0,  4'd14, 32'h00001234, 4'd0,  6'b000001}, // opcode 0x3f
    '{32'h00221801, 1'b0, 5'd0,  4'd14, 32'h00001801, 4'd0,  6'b000001}  // special funct 0x01
};

`endif

// ==== test/tb_decode_top.sv ====
`timescale 1ns/1ps

module tb_decode_top;

    `include "tb_decode_vectors.svh"

    // each step takes two cycles and the random pass repeats dropped rows.
    localparam int TIMEOUT_CYCLES = NUM_VECTORS * 4 + 200;

    logic                  clk;
    logic                  reset;
    logic [31:0]           inst;
    logic                  inst_valid;
    logic                  stall;
    logic                  flush;
    mips_decode_pkg::dec_t dec;

    integer seed;
    logic   exp_valid;
    int     exp_row;

    decode_top i_decode_top (
        .clk        (clk),
        .reset      (reset),
        .inst       (inst),
        .inst_valid (inst_valid),
        .stall      (stall),
        .flush      (flush),
        .dec        (dec)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout after %0d cycles before all rows were checked", TIMEOUT_CYCLES);
        $display("Result: FAILED");
        $fatal(1, "watchdog expired");
    end

    task automatic value_error(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        $display("ERR %0t %s expected 0x%0h actual 0x%0h", $time, name, expected, actual);
        $display("Result: FAILED");
        $fatal(1, "decode check failed");
    endtask

    task automatic check_row(input int row);
        vector_t    v;
        logic [5:0] flags;
        v     = VECTORS[row];
        flags = {dec.is_branch, dec.is_j_imme, dec.is_jr, dec.is_hilo, dec.imm_src,
                 dec.reserved};
        assert (dec.w_reg_ena == v.w_ena)
            else value_error("dec.w_reg_ena", 32'(v.w_ena), 32'(dec.w_reg_ena));
        assert (dec.w_reg_dst == v.w_dst)
            else value_error("dec.w_reg_dst", 32'(v.w_dst), 32'(dec.w_reg_dst));
        assert (dec.alu_op == v.alu)
            else value_error("dec.alu_op", 32'(v.alu), 32'(dec.alu_op));
        assert (dec.imm32 == v.imm)
            else value_error("dec.imm32", v.imm, dec.imm32);
        assert (dec.mem_op == v.mem)
            else value_error("dec.mem_op", 32'(v.mem), 32'(dec.mem_op));
        assert (flags == v.flags)
            else value_error("dec flags", 32'(v.flags), 32'(flags));
        assert (dec.j_target26 == v.inst[25:0])
            else value_error("dec.j_target26", 32'(v.inst[25:0]), 32'(dec.j_target26));
        assert (dec.rs == v.inst[25:21])
            else value_error("dec.rs", 32'(v.inst[25:21]), 32'(dec.rs));
        assert (dec.rt == v.inst[20:16])
            else value_error("dec.rt", 32'(v.inst[20:16]), 32'(dec.rt));
        assert (dec.sa == v.inst[10:6])
            else value_error("dec.sa", 32'(v.inst[10:6]), 32'(dec.sa));
    endtask

    // present a row for one edge, then check the registered decode.
    task automatic step(input int row, input logic st, input logic fl);
        @(posedge clk);
        inst       <= VECTORS[row].inst;
        inst_valid <= 1'b1;
        stall      <= st;
        flush      <= fl;
        @(posedge clk);
        @(negedge clk);
        if (fl) begin
            exp_valid = 1'b0;
        end else if (!st) begin
            exp_valid = 1'b1;
            exp_row   = row;
        end
        assert (dec.valid == exp_valid)
            else value_error("dec.valid", 32'(exp_valid), 32'(dec.valid));
        if (exp_valid) begin
            check_row(exp_row);
        end
    endtask

    initial begin
        logic [31:0] r;
        int          i;
        seed       = 32'h58a6f16f;
        exp_valid  = 1'b0;
        exp_row    = 0;
        reset      = 1'b1;
        // a valid word during reset must not reach the decode.
        inst       = 32'h0;
        inst_valid = 1'b1;
        stall      = 1'b0;
        flush      = 1'b0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        assert (dec.valid == 1'b0)
            else value_error("dec.valid", 32'd0, 32'(dec.valid));

        for (i = 0; i < NUM_VECTORS; i++) begin
            step(i, 1'b0, 1'b0);
        end

        // hold under stall, then flush while still stalled.
        step(0, 1'b0, 1'b0);
        step(1, 1'b1, 1'b0);
        step(1, 1'b1, 1'b1);

        // a stalled or flushed row is presented again.
        i = 0;
        while (i < NUM_VECTORS) begin
            r = $random(seed);
            step(i, r[1:0] == 2'b00, r[4:2] == 3'b000);
            if (r[1:0] != 2'b00 && r[4:2] != 3'b000) begin
                i++;
            end
        end

        $display("Result: PASSED");
        $finish;
    end

endmodule
